// File: clkgen_top.f
logic/clkgen_pkg.sv
logic/clock_divider.sv
logic/clkgen_regs.sv
logic/clkgen_top.sv
verif/clkgen_properties.sv
verif/clkgen_checker.sv
verif/clkgen_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the clock generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module clkgen_tb -f clkgen_top.f -o clkgen_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/clkgen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verif/clkgen_tb.sv
// Testbench for the clock generator
// Clock, reset, AXI4-Lite bus tasks, reference period and test sequence

`timescale 1ns/1ps
`default_nettype none

module clkgen_tb;

  localparam int CLK_NS      = 8;    // clkin period
  localparam int RESET_LEN   = 8;    // Cycles in reset
  localparam int DRIVE_DELAY = 1;    // Input skew after the edge
  localparam int WAIT_LIMIT  = 200;  // Cycles before a wait gives up

  logic                  clkin = 1'b0;
  logic                  reset;
  clkgen_pkg::axil_req_t req;
  clkgen_pkg::axil_rsp_t rsp;
  logic                  clkout;
  logic                  clkout90;
  int unsigned           lcg_state = 56;  // Back-pressure generator

  clkgen_pkg::axil_data_t rd_data;
  clkgen_pkg::axil_resp_t resp;
  int p;
  int limit;
  int mism;

  always #(CLK_NS / 2) clkin = ~clkin;

  clkgen_top dut (
    .clkin    (clkin),
    .reset    (reset),
    .axil_req (req),
    .axil_rsp (rsp),
    .clkout   (clkout),
    .clkout90 (clkout90)
  );

  clkgen_checker chk (
    .run      (dut.run),  // Internal enable for the first-edge delay
    .clkout   (clkout),
    .clkout90 (clkout90)
  );

  // ################################################
  // Helpers
  // ################################################
  // Period in clkin cycles, 0 stopped, 1 bypass
  function automatic int expected_period(input int code);
    if (code <= 6) return 128 >> code;
    if (code == 7) return 1;
    return 0;
  endfunction

  function int ready_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % 4);  // 0 to 3 cycles
  endfunction

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clkin);
    #DRIVE_DELAY;
  endtask

  task automatic axil_write(input clkgen_pkg::axil_addr_t addr,
                            input clkgen_pkg::axil_data_t data,
                            output clkgen_pkg::axil_resp_t wresp);
    int n;
    n = 0;
    req.awaddr  = addr;
    req.wdata   = data;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    next_cycle();
    while (!rsp.awready || !rsp.wready) begin  // Both readies in the same cycle
      n++;
      if (n > WAIT_LIMIT) abort_run("write address and data were never accepted");
      next_cycle();
    end
    next_cycle();                     // Hold through the accept cycle
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    repeat (ready_delay()) next_cycle();
    n = 0;
    while (!rsp.bvalid) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("write response never arrived");
      next_cycle();
    end
    wresp      = rsp.bresp;
    req.bready = 1'b1;
    next_cycle();
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input clkgen_pkg::axil_addr_t addr,
                           output clkgen_pkg::axil_data_t data,
                           output clkgen_pkg::axil_resp_t rresp);
    int n;
    n = 0;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    next_cycle();
    while (!rsp.arready) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("read address was never accepted");
      next_cycle();
    end
    next_cycle();
    req.arvalid = 1'b0;
    repeat (ready_delay()) next_cycle();
    n = 0;
    while (!rsp.rvalid) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("read response never arrived");
      next_cycle();
    end
    data       = rsp.rdata;
    rresp      = rsp.rresp;
    req.rready = 1'b1;
    next_cycle();
    req.rready = 1'b0;
  endtask

  // ################################################
  // Test sequence
  // ################################################
  initial begin
    req   = '0;
    reset = 1'b1;
    repeat (RESET_LEN) @(posedge clkin);
    #DRIVE_DELAY;
    reset = 1'b0;

    // Reset state
    axil_read(clkgen_pkg::REG_CTRL, rd_data, resp);
    chk.check("reset_ctrl", 0, rd_data);
    axil_read(clkgen_pkg::REG_TICKS, rd_data, resp);
    chk.check("reset_ticks", 0, rd_data);
    axil_read(clkgen_pkg::REG_ID, rd_data, resp);
    chk.check("reset_id", clkgen_pkg::CLKGEN_ID, rd_data);
    repeat (50) next_cycle();
    chk.check("idle_outputs_low", 0, chk.n_rise + chk.n_r90);

    // Register access
    axil_write(clkgen_pkg::REG_CTRL, 32'h05, resp);
    chk.check("ctrl_write_okay", clkgen_pkg::RESP_OKAY, resp);
    axil_read(clkgen_pkg::REG_CTRL, rd_data, resp);
    chk.check("ctrl_readback_05", 32'h05, rd_data);
    axil_write(clkgen_pkg::REG_CTRL, 32'h0B, resp);
    axil_read(clkgen_pkg::REG_CTRL, rd_data, resp);
    chk.check("ctrl_readback_0b", 32'h0B, rd_data);
    axil_write(8'h10, 32'h1234, resp);
    chk.check("unmapped_write_slverr", clkgen_pkg::RESP_SLVERR, resp);
    axil_read(8'h10, rd_data, resp);
    chk.check("unmapped_read_slverr", clkgen_pkg::RESP_SLVERR, resp);
    chk.check("unmapped_read_zero", 0, rd_data);
    for (int i = 0; i < 4; i++) begin
      axil_read(clkgen_pkg::REG_ID, rd_data, resp);
      chk.check($sformatf("order_id_%0d", i), clkgen_pkg::CLKGEN_ID, rd_data);
      axil_read(clkgen_pkg::REG_CTRL, rd_data, resp);
      chk.check($sformatf("order_ctrl_%0d", i), 32'h0B, rd_data);
    end
    axil_write(clkgen_pkg::REG_CTRL, 32'h00, resp);

    // Divide ratios and 90 degree phase
    for (int code = 0; code <= 6; code++) begin
      p = expected_period(code);
      chk.clear_counts();
      axil_write(clkgen_pkg::REG_CTRL, 32'h10 | code, resp);
      limit = 4 * p + WAIT_LIMIT;
      while (chk.n_rise < 3) begin
        limit--;
        if (limit == 0) abort_run($sformatf("clkout stayed idle for code %0d", code));
        next_cycle();
      end
      chk.check($sformatf("first_edge_code%0d", code), p * CLK_NS, chk.first_ns());
      chk.check($sformatf("period_code%0d", code), p * CLK_NS, chk.period_ns());
      chk.check($sformatf("high_code%0d", code), p * CLK_NS / 2, chk.high_ns);
      chk.check($sformatf("phase90_code%0d", code),
                (p >= 4) ? (p / 4) * CLK_NS : CLK_NS / 2, chk.phase_ns);
      axil_write(clkgen_pkg::REG_CTRL, 32'h00, resp);
    end

    // Bypass follows clkin on both edges
    axil_write(clkgen_pkg::REG_CTRL, 32'h10 | clkgen_pkg::DIV_BYPASS, resp);
    repeat (4) next_cycle();
    mism = 0;
    repeat (20) begin
      @(posedge clkin);
      #2;
      if (clkout !== clkin) mism++;
      @(negedge clkin);
      #2;
      if (clkout !== clkin) mism++;
    end
    chk.check("bypass_follows_clkin", 0, mism);
    axil_write(clkgen_pkg::REG_CTRL, 32'h00, resp);

    // Stop codes hold clkout low
    for (int code = 8; code <= 15; code++) begin
      chk.clear_counts();
      axil_write(clkgen_pkg::REG_CTRL, 32'h10 | code, resp);
      repeat (300) next_cycle();
      chk.check($sformatf("stopped_code%0d", code), 0, chk.n_rise + clkout);
      axil_write(clkgen_pkg::REG_CTRL, 32'h00, resp);
    end

    // Tick counter against observed edges
    axil_write(clkgen_pkg::REG_TICKS, 32'h0, resp);
    chk.clear_counts();
    axil_write(clkgen_pkg::REG_CTRL, 32'h14, resp);  // Divide by 8
    limit = 20 * 8 + WAIT_LIMIT;
    while (chk.n_rise < 10) begin
      limit--;
      if (limit == 0) abort_run("too few clkout edges in the tick window");
      next_cycle();
    end
    axil_write(clkgen_pkg::REG_CTRL, 32'h04, resp);
    axil_read(clkgen_pkg::REG_TICKS, rd_data, resp);
    chk.check("ticks_match_edges", chk.n_rise, rd_data);
    axil_write(clkgen_pkg::REG_TICKS, 32'h5A, resp);
    axil_read(clkgen_pkg::REG_TICKS, rd_data, resp);
    chk.check("ticks_cleared", 0, rd_data);

    $display("%0d checks passed, %0d checks failed", chk.n_pass, chk.n_fail);
    if (chk.n_fail == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/clkgen_checker.sv
// Edge watcher for clkout and clkout90
// Records edge times, counts rising edges and reports each compare

`timescale 1ns/1ps
`default_nettype none

module clkgen_checker (
  input logic run,       // Divider enable from CTRL
  input logic clkout,
  input logic clkout90
);

  realtime t_run   = 0;  // Last run rise
  realtime t_first = 0;  // First clkout rise after clear
  realtime t_rise  = 0;  // Latest clkout rise
  realtime t_prev  = 0;  // Rise before that

  int n_rise   = 0;      // clkout rises since clear
  int n_r90    = 0;      // clkout90 rises since clear
  int high_ns  = 0;      // Last measured high time
  int phase_ns = 0;      // clkout to clkout90 delay
  int n_pass   = 0;
  int n_fail   = 0;

  // ################################################
  // Edge capture
  // ################################################
  always @(posedge run) t_run = $realtime;

  always @(posedge clkout) begin
    if (n_rise == 0) t_first = $realtime;  // Start of this window
    t_prev = t_rise;
    t_rise = $realtime;
    n_rise = n_rise + 1;
  end

  always @(negedge clkout) high_ns = $rtoi($realtime - t_rise + 0.5);

  always @(posedge clkout90) begin
    phase_ns = $rtoi($realtime - t_rise + 0.5);  // From latest clkout rise
    n_r90    = n_r90 + 1;
  end

  function automatic int first_ns();
    return $rtoi(t_first - t_run + 0.5);  // Run to first rise
  endfunction

  function automatic int period_ns();
    return $rtoi(t_rise - t_prev + 0.5);
  endfunction

  task automatic clear_counts();
    n_rise = 0;
    n_r90  = 0;
  endtask

  // ################################################
  // Compare and report
  // ################################################
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp === act) begin
      n_pass = n_pass + 1;
      $display("PASS %s", name);
    end else begin
      n_fail = n_fail + 1;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

endmodule

`default_nettype wire

// File: verif/clkgen_properties.sv
// Bound assertions for the clock generator
// AXI response stability, tick gating and reset state of the outputs

`timescale 1ns/1ps
`default_nettype none

module clkgen_properties (
  input logic                  clkin,
  input logic                  reset,
  input clkgen_pkg::axil_req_t axil_req,
  input clkgen_pkg::axil_rsp_t axil_rsp,
  input logic                  run,
  input logic                  tick,
  input logic                  clkout,
  input logic                  clkout90
);

  // ################################################
  // Response channels
  // ################################################
  assert property (@(posedge clkin) disable iff (reset)
    (axil_rsp.bvalid && !axil_req.bready) |=> $stable(axil_rsp.bresp))
    else $error("bresp changed while bvalid waited for bready");

  assert property (@(posedge clkin) disable iff (reset)
    (axil_rsp.rvalid && !axil_req.rready) |=> $stable(axil_rsp.rdata))
    else $error("rdata changed while rvalid waited for rready");

  assert property (@(posedge clkin) disable iff (reset)
    (axil_rsp.rvalid && !axil_req.rready) |=> $stable(axil_rsp.rresp))
    else $error("rresp changed while rvalid waited for rready");

  // Divider side, no stale pulse when the counter restarts
  assert property (@(posedge clkin) disable iff (reset) !run |=> !tick)
    else $error("tick pulsed in the cycle after run was low");

  assert property (@(posedge clkin) reset |-> (!clkout && !clkout90 &&
    !axil_rsp.bvalid && !axil_rsp.rvalid && !axil_rsp.awready && !axil_rsp.arready))
    else $error("outputs not idle during reset");

endmodule

// Top level sees both the register block and the divider
bind clkgen_top clkgen_properties props (
  .clkin    (clkin),
  .reset    (reset),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .run      (run),
  .tick     (tick),
  .clkout   (clkout),
  .clkout90 (clkout90)
);

`default_nettype wire

// File: logic/clkgen_top.sv
// Clock generator top level
// Register block driving the power-of-two divider

`timescale 1ns/1ps
`default_nettype none

module clkgen_top (
  input  logic                  clkin,     // Reference clock
  input  logic                  reset,     // Async, active high
  input  clkgen_pkg::axil_req_t axil_req,  // Host requests
  output clkgen_pkg::axil_rsp_t axil_rsp,  // Host responses
  output logic                  clkout,    // Divided clock
  output logic                  clkout90   // Quarter-period shifted copy
);

  // ################################################
  // Internal connections
  // ################################################
  clkgen_pkg::divcfg_t divcfg;  // Active divide code
  logic                run;     // Divider enable
  logic                tick;    // Period pulse back to TICKS

  // Host register block
  clkgen_regs u_regs (
    .clkin    (clkin),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .tick     (tick),
    .divcfg   (divcfg),
    .run      (run)
  );

  // Divider and phase outputs
  clock_divider u_divider (
    .clkin    (clkin),
    .reset    (reset),
    .divcfg   (divcfg),
    .run      (run),
    .clkout   (clkout),
    .clkout90 (clkout90),
    .tick     (tick)
  );

endmodule

`default_nettype wire

// File: logic/clkgen_regs.sv
// AXI4-Lite register block for the clock generator
// CTRL with divide code and run, saturating TICKS counter, ID word

`timescale 1ns/1ps
`default_nettype none

module clkgen_regs (
  input  logic                  clkin,
  input  logic                  reset,
  input  clkgen_pkg::axil_req_t axil_req,  // Master side of the bus
  output clkgen_pkg::axil_rsp_t axil_rsp,  // Slave side of the bus
  input  logic                  tick,      // Divided period done
  output clkgen_pkg::divcfg_t   divcfg,    // CTRL bits 3:0
  output logic                  run        // CTRL bit 4
);

  // Same three steps on both channels
  typedef enum logic [1:0] {
    CH_IDLE,    // Waiting for a request
    CH_ACCEPT,  // Ready high for one cycle
    CH_RESP     // Valid held until taken
  } chan_state_t;

  chan_state_t wr_state;
  chan_state_t rd_state;

  clkgen_pkg::axil_resp_t  bresp_q;
  clkgen_pkg::axil_resp_t  rresp_q;
  clkgen_pkg::axil_resp_t  rresp_d;
  clkgen_pkg::axil_data_t  rdata_q;
  clkgen_pkg::axil_data_t  rdata_d;
  clkgen_pkg::tick_count_t ticks;

  logic wr_fire;    // Write address and data taken
  logic rd_fire;    // Read address taken
  logic wr_mapped;  // Write hits a register
  logic wr_ctrl;
  logic wr_ticks;

  // ################################################
  // Write channel
  // ################################################
  assign wr_fire   = (wr_state == CH_ACCEPT);
  assign wr_mapped = (axil_req.awaddr == clkgen_pkg::REG_CTRL) ||
                     (axil_req.awaddr == clkgen_pkg::REG_TICKS) ||
                     (axil_req.awaddr == clkgen_pkg::REG_ID);
  assign wr_ctrl   = wr_fire && (axil_req.awaddr == clkgen_pkg::REG_CTRL);
  assign wr_ticks  = wr_fire && (axil_req.awaddr == clkgen_pkg::REG_TICKS);

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      wr_state <= CH_IDLE;
    end else begin
      case (wr_state)
        CH_IDLE: begin
          if (axil_req.awvalid && axil_req.wvalid) begin
            wr_state <= CH_ACCEPT;   // Both halves present
          end
        end
        CH_ACCEPT: wr_state <= CH_RESP;
        CH_RESP: begin
          if (axil_req.bready) begin
            wr_state <= CH_IDLE;
          end
        end
        default: wr_state <= CH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clkin) begin
    if (wr_fire) begin
      bresp_q <= wr_mapped ? clkgen_pkg::RESP_OKAY : clkgen_pkg::RESP_SLVERR;
    end
  end

  // ################################################
  // Read channel
  // ################################################
  assign rd_fire = (rd_state == CH_ACCEPT);

  always_comb begin
    rdata_d = '0;                    // Unmapped reads give zero
    rresp_d = clkgen_pkg::RESP_OKAY;
    case (axil_req.araddr)
      clkgen_pkg::REG_CTRL:  rdata_d = {27'd0, run, divcfg};
      clkgen_pkg::REG_TICKS: rdata_d = {16'd0, ticks};
      clkgen_pkg::REG_ID:    rdata_d = clkgen_pkg::CLKGEN_ID;
      default:               rresp_d = clkgen_pkg::RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      rd_state <= CH_IDLE;
    end else begin
      case (rd_state)
        CH_IDLE: begin
          if (axil_req.arvalid) begin
            rd_state <= CH_ACCEPT;
          end
        end
        CH_ACCEPT: rd_state <= CH_RESP;
        CH_RESP: begin
          if (axil_req.rready) begin
            rd_state <= CH_IDLE;
          end
        end
        default: rd_state <= CH_IDLE;
      endcase
    end
  end

  // Read data sampled once and held
  always_ff @(posedge clkin) begin
    if (rd_fire) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  // ################################################
  // Registers
  // ################################################
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      divcfg <= '0;
      run    <= 1'b0;
    end else if (wr_ctrl) begin
      divcfg <= axil_req.wdata[3:0];
      run    <= axil_req.wdata[4];
    end
  end

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      ticks <= '0;
    end else if (wr_ticks) begin
      ticks <= '0;                   // Any data clears
    end else if (tick && run && (ticks != '1)) begin
      ticks <= ticks + 16'd1;        // Stops at all ones
    end
  end

  // Response bundle
  always_comb begin
    axil_rsp.awready = (wr_state == CH_ACCEPT);
    axil_rsp.wready  = (wr_state == CH_ACCEPT);
    axil_rsp.bvalid  = (wr_state == CH_RESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = (rd_state == CH_ACCEPT);
    axil_rsp.rvalid  = (rd_state == CH_RESP);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

// File: logic/clock_divider.sv
// Power-of-two clock divider with 90 degree copy and period tick
// Codes 0 to 6 divide by 128 down to 2, code 7 bypasses, the rest stop

`timescale 1ns/1ps
`default_nettype none

module clock_divider (
  input  logic                clkin,     // Source clock
  input  logic                reset,     // Async, active high
  input  clkgen_pkg::divcfg_t divcfg,    // Divide code from CTRL
  input  logic                run,       // Enable, restarts when low
  output logic                clkout,    // Divided clock
  output logic                clkout90,  // Same, shifted by a quarter period
  output logic                tick       // One pulse per divided period
);

  clkgen_pkg::divdec_t period;       // Decoded period length
  clkgen_pkg::divdec_t half_pos;     // Falling point of clkout
  clkgen_pkg::divdec_t quarter_pos;  // Rising point of clkout90
  clkgen_pkg::divdec_t three_q_pos;  // Falling point of clkout90
  clkgen_pkg::divdec_t counter;      // Runs 1 up to period

  logic counting;       // Divider active
  logic bypass_sel;     // clkin passed through
  logic div2_sel;       // Divide by two needs the falling edge
  logic armed;          // First clkout edge already produced
  logic full_match;
  logic half_match;
  logic quarter_match;
  logic three_q_match;
  logic clkout_reg;
  logic clkout90_div4;  // Quarter phase for P of 4 and up
  logic clkout90_div2;  // Half-cycle phase for P of 2
  logic tick_reg;

  // ################################################
  // Code decode and match points
  // ################################################
  always_comb begin
    case (divcfg)
      4'd0:                   period = 8'd128;
      4'd1:                   period = 8'd64;
      4'd2:                   period = 8'd32;
      4'd3:                   period = 8'd16;
      4'd4:                   period = 8'd8;
      4'd5:                   period = 8'd4;
      clkgen_pkg::DIV_BY2:    period = 8'd2;
      clkgen_pkg::DIV_BYPASS: period = 8'd1;  // Match every cycle
      default:                period = 8'd0;  // Stopped
    endcase
  end

  assign half_pos    = {1'b0, period[7:1]};
  assign quarter_pos = {2'b00, period[7:2]};
  assign three_q_pos = quarter_pos + half_pos;

  assign counting   = run && (period != 8'd0);
  assign bypass_sel = run && (divcfg == clkgen_pkg::DIV_BYPASS);
  assign div2_sel   = (divcfg == clkgen_pkg::DIV_BY2);

  assign full_match    = counting && (counter == period);
  assign half_match    = counting && (counter == half_pos);
  assign quarter_match = counting && armed && (counter == quarter_pos);
  assign three_q_match = counting && armed && (counter == three_q_pos);

  // ################################################
  // Period counter
  // ################################################
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      counter  <= 8'd1;
      armed    <= 1'b0;
      tick_reg <= 1'b0;
    end else if (!counting) begin
      counter  <= 8'd1;              // Restart from the top
      armed    <= 1'b0;
      tick_reg <= 1'b0;
    end else begin
      counter  <= full_match ? 8'd1 : counter + 8'd1;  // Self restarting
      armed    <= armed | full_match;
      tick_reg <= full_match;        // Lines up with clkout rise
    end
  end

  // Output clock registers on the rising edge
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      clkout_reg    <= 1'b0;
      clkout90_div4 <= 1'b0;
    end else if (!counting) begin
      clkout_reg    <= 1'b0;
      clkout90_div4 <= 1'b0;
    end else begin
      if (full_match && !bypass_sel) begin
        clkout_reg <= 1'b1;          // Start of period
      end else if (half_match) begin
        clkout_reg <= 1'b0;          // Mid period
      end
      if (quarter_match) begin
        clkout90_div4 <= 1'b1;
      end else if (three_q_match) begin
        clkout90_div4 <= 1'b0;
      end
    end
  end

  // Divide by two phase from the falling edge
  always_ff @(negedge clkin or posedge reset) begin
    if (reset) begin
      clkout90_div2 <= 1'b0;
    end else if (!counting) begin
      clkout90_div2 <= 1'b0;
    end else if (armed && half_match) begin
      clkout90_div2 <= 1'b1;         // Half cycle after clkout rise
    end else if (full_match) begin
      clkout90_div2 <= 1'b0;
    end
  end

  // ################################################
  // Outputs
  // ################################################
  assign clkout   = bypass_sel ? clkin : (clkout_reg & run);
  assign clkout90 = run & (div2_sel ? clkout90_div2 : clkout90_div4);
  assign tick     = tick_reg & run;  // Quiet as soon as run drops

endmodule

`default_nettype wire

// File: logic/clkgen_pkg.sv
// Shared types for the clock generator
// AXI4-Lite request and response bundles, register map and divide codes

`default_nettype none

package clkgen_pkg;

  // ################################################
  // Widths that carry a meaning
  // ################################################
  typedef logic [3:0]  divcfg_t;      // Divide code
  typedef logic [7:0]  divdec_t;      // Period in clkin cycles
  typedef logic [15:0] tick_count_t;  // Completed divided periods
  typedef logic [7:0]  axil_addr_t;   // Byte address
  typedef logic [31:0] axil_data_t;   // Bus data word
  typedef logic [1:0]  axil_resp_t;   // OKAY or SLVERR

  // Everything the master drives
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

  // ################################################
  // Constants
  // ################################################
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  localparam axil_addr_t REG_CTRL  = 8'h00;  // Divide code and run
  localparam axil_addr_t REG_TICKS = 8'h04;  // Period counter
  localparam axil_addr_t REG_ID    = 8'h08;  // Read-only ident

  localparam axil_data_t CLKGEN_ID = 32'h434B_4701;  // "CKG" plus revision

  localparam divcfg_t DIV_BY2    = 4'd6;  // Shortest divided period
  localparam divcfg_t DIV_BYPASS = 4'd7;  // clkin straight through

endpackage

`default_nettype wire
